// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - design/rv_pkg.sv
  - design/decode_if.sv
  - design/instr_fetch.sv
  - design/rv_decoder.sv
  - design/rv_alu.sv
  - design/reg_file.sv
  - design/reg_readout.sv
  - design/rv_core_top.sv
  - target: test
    files:
      - bench/tb_clock.sv
      - bench/tb_rv_core.sv

// ==== bench/tb_clock.sv ====
// Testbench clock and reset source; 40 ns clock, reset low for 4 cycles, rerun on restart
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
   input  logic restart,
   output logic clk,
   output logic arst_n
);

   // Half period of 20 ns
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Reset held for 4 rising edges, released on a falling edge
   initial begin
      arst_n = 1'b0;
      forever begin
         repeat (4) @(posedge clk);
         @(negedge clk);
         arst_n = 1'b1;
         // A restart pulse asserts reset again at once
         @(posedge restart);
         arst_n = 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== bench/tb_rv_core.sv ====
// Testbench for the RV32I core; loads programs, runs them and compares registers with a model
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

   logic               clk;
   logic               arst_n;
   logic               restart;
   logic               run;
   logic               load_req;
   rv_pkg::imem_addr_t load_addr;
   rv_pkg::word_t      load_data;
   logic               load_ack;
   logic               rd_req;
   rv_pkg::reg_idx_t   rd_index;
   logic               rd_ack;
   rv_pkg::word_t      rd_data;
   logic               halted;

   // Program image, expected registers, LFSR state
   rv_pkg::word_t      prog [rv_pkg::IMEM_WORDS];
   rv_pkg::word_t      exp_regs [rv_pkg::REG_COUNT];
   logic [31:0]        lfsr_state;
   int                 error_count;

   tb_clock clock_gen (
      .restart (restart),
      .clk     (clk),
      .arst_n  (arst_n)
   );

   rv_core_top UUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .run       (run),
      .load_req  (load_req),
      .load_addr (load_addr),
      .load_data (load_data),
      .load_ack  (load_ack),
      .rd_req    (rd_req),
      .rd_index  (rd_index),
      .rd_ack    (rd_ack),
      .rd_data   (rd_data),
      .halted    (halted)
   );

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] get_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic void stop_on_error(input string why);
      error_count++;
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1, "run stopped at first error");
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         stop_on_error($sformatf("mismatch %s: got 0x%08h expected 0x%08h",
                                 name, got, expected));
      end
   endtask

   // Instruction encoders straight from the RV32I formats
   function automatic rv_pkg::word_t enc_r(input logic alt, input logic [2:0] f3,
                                           input rv_pkg::reg_idx_t rd, rs1, rs2);
      return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
   endfunction

   function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                           input rv_pkg::reg_idx_t rd, rs1);
      return {imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM};
   endfunction

   function automatic rv_pkg::word_t enc_u(input rv_pkg::opcode_t opc, input logic [19:0] imm,
                                           input rv_pkg::reg_idx_t rd);
      return {imm, rd, opc};
   endfunction

   function automatic rv_pkg::word_t enc_j(input int off, input rv_pkg::reg_idx_t rd);
      logic [20:0] o;
      o = off[20:0];
      return {o[20], o[10:1], o[11], o[19:12], rd, rv_pkg::OPC_JAL};
   endfunction

   function automatic rv_pkg::word_t enc_b(input int off, input logic [2:0] f3,
                                           input rv_pkg::reg_idx_t rs1, rs2);
      logic [12:0] o;
      o = off[12:0];
      return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], rv_pkg::OPC_BRANCH};
   endfunction

   // Random R or I ALU instruction with legal shift immediates
   function automatic rv_pkg::word_t random_alu_instr();
      logic [2:0]       f3;
      logic [11:0]      imm;
      rv_pkg::reg_idx_t rd;
      rv_pkg::reg_idx_t rs1;
      rv_pkg::reg_idx_t rs2;
      f3  = 3'(get_bits(3));
      rd  = rv_pkg::reg_idx_t'(get_bits(5));
      rs1 = rv_pkg::reg_idx_t'(get_bits(5));
      rs2 = rv_pkg::reg_idx_t'(get_bits(5));
      if (get_bits(1) == 1) begin
         // Bit 30 only means something for ADD/SUB and SRL/SRA
         return enc_r((f3 == 3'd0 || f3 == 3'd5) ? 1'(get_bits(1)) : 1'b0, f3, rd, rs1, rs2);
      end
      imm = 12'(get_bits(12));
      if (f3 == 3'd1) begin
         imm[11:5] = '0;
      end else if (f3 == 3'd5) begin
         imm[11:5] = {1'b0, 1'(get_bits(1)), 5'b0};
      end
      return enc_i(imm, f3, rd, rs1);
   endfunction

   // Instruction-set model from xN = N up to the jump-to-self
   function automatic void run_model(input int len);
      rv_pkg::word_t   r [rv_pkg::REG_COUNT];
      rv_pkg::word_t   pc;
      rv_pkg::word_t   npc;
      rv_pkg::word_t   ins;
      rv_pkg::word_t   a;
      rv_pkg::word_t   b2;
      rv_pkg::word_t   res;
      rv_pkg::word_t   imm_j;
      rv_pkg::word_t   imm_b;
      rv_pkg::opcode_t opc;
      logic [2:0]      f3;
      logic            alt;
      logic            wr;
      logic            take;
      logic            done;
      int              steps;
      for (int i = 0; i < rv_pkg::REG_COUNT; i++) begin
         r[i] = rv_pkg::word_t'(i);
      end
      pc    = '0;
      done  = 1'b0;
      steps = 0;
      while (!done) begin
         if (steps == 1000 || pc[31:2] >= len) begin
            stop_on_error("reference model left the program without a jump-to-self");
         end else begin
            ins   = prog[pc[7:2]];
            opc   = ins[6:0];
            f3    = ins[14:12];
            a     = r[ins[19:15]];
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            res   = '0;
            wr    = 1'b0;
            take  = 1'b0;
            npc   = pc + 32'd4;
            if (opc == rv_pkg::OPC_OP || opc == rv_pkg::OPC_OP_IMM) begin
               wr  = 1'b1;
               b2  = (opc == rv_pkg::OPC_OP) ? r[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
               alt = ins[30] && (opc == rv_pkg::OPC_OP || f3 == 3'd5);
               case (f3)
                  3'd0:    res = alt ? a - b2 : a + b2;
                  3'd1:    res = a << b2[4:0];
                  3'd2:    res = ($signed(a) < $signed(b2)) ? 32'd1 : 32'd0;
                  3'd3:    res = (a < b2) ? 32'd1 : 32'd0;
                  3'd4:    res = a ^ b2;
                  3'd5:    res = alt ? rv_pkg::word_t'($signed(a) >>> b2[4:0]) : a >> b2[4:0];
                  3'd6:    res = a | b2;
                  default: res = a & b2;
               endcase
            end else if (opc == rv_pkg::OPC_LUI) begin
               wr  = 1'b1;
               res = {ins[31:12], 12'b0};
            end else if (opc == rv_pkg::OPC_AUIPC) begin
               wr  = 1'b1;
               res = pc + {ins[31:12], 12'b0};
            end else if (opc == rv_pkg::OPC_JAL) begin
               // Link written even on the final jump
               wr   = 1'b1;
               res  = pc + 32'd4;
               npc  = pc + imm_j;
               done = (imm_j == '0);
            end else if (opc == rv_pkg::OPC_BRANCH) begin
               b2 = r[ins[24:20]];
               case (f3)
                  3'd0:    take = (a == b2);
                  3'd1:    take = (a != b2);
                  3'd4:    take = ($signed(a) < $signed(b2));
                  3'd5:    take = ($signed(a) >= $signed(b2));
                  3'd6:    take = (a < b2);
                  default: take = (a >= b2);
               endcase
               if (take) begin
                  npc = pc + imm_b;
               end
            end else begin
               stop_on_error("reference model met an opcode outside the kept set");
            end
            if (wr && ins[11:7] != '0) begin
               r[ins[11:7]] = res;
            end
            pc = npc;
            steps++;
         end
      end
      exp_regs = r;
   endfunction

   function automatic logic probe(input string name);
      if (name == "load_ack") begin
         return load_ack;
      end else if (name == "rd_ack") begin
         return rd_ack;
      end else if (name == "halted") begin
         return halted;
      end
      return arst_n;
   endfunction

   // Polls on falling edges up to a per-call cycle limit
   task automatic wait_level(input string name, input logic level, input int limit);
      int cycles;
      cycles = 0;
      while (probe(name) !== level) begin
         if (cycles == limit) begin
            stop_on_error($sformatf("timeout: %s did not reach %0b within %0d cycles",
                                    name, level, limit));
         end else begin
            @(negedge clk);
            cycles++;
         end
      end
   endtask

   task automatic load_word(input int addr, input rv_pkg::word_t data);
      @(negedge clk);
      load_addr = rv_pkg::imem_addr_t'(addr);
      load_data = data;
      load_req  = 1'b1;
      wait_level("load_ack", 1'b1, 8);
      load_req = 1'b0;
      wait_level("load_ack", 1'b0, 8);
   endtask

   task automatic read_reg(input rv_pkg::reg_idx_t idx, output rv_pkg::word_t data);
      @(negedge clk);
      rd_index = idx;
      rd_req   = 1'b1;
      wait_level("rd_ack", 1'b1, 8);
      data   = rd_data;
      rd_req = 1'b0;
      wait_level("rd_ack", 1'b0, 8);
   endtask

   task automatic check_all_regs();
      rv_pkg::word_t got;
      for (int i = 0; i < rv_pkg::REG_COUNT; i++) begin
         read_reg(rv_pkg::reg_idx_t'(i), got);
         check_value($sformatf("x%0d", i), got, exp_regs[i]);
      end
   endtask

   // Fresh reset, load, run to halt, compare every register
   task automatic run_program(input int len);
      @(negedge clk);
      restart = 1'b1;
      @(negedge clk);
      restart = 1'b0;
      wait_level("arst_n", 1'b1, 10);
      for (int i = 0; i < len; i++) begin
         load_word(i, prog[i]);
      end
      run_model(len);
      @(negedge clk);
      run = 1'b1;
      wait_level("halted", 1'b1, 1000);
      @(negedge clk);
      run = 1'b0;
      check_all_regs();
   endtask

   // Request held high while the index moves
   // Ack and data stay put until req drops
   task automatic held_readout(input rv_pkg::reg_idx_t idx);
      rv_pkg::word_t first;
      @(negedge clk);
      rd_index = idx;
      rd_req   = 1'b1;
      wait_level("rd_ack", 1'b1, 8);
      first = rd_data;
      check_value("rd_data", first, exp_regs[idx]);
      repeat (6) begin
         @(negedge clk);
         rd_index = ~idx;
         check_value("rd_ack", rd_ack, 1);
         check_value("rd_data", rd_data, first);
      end
      rd_req = 1'b0;
      wait_level("rd_ack", 1'b0, 8);
   endtask

   initial begin
      logic [2:0]  branch_funct [6];
      logic [11:0] pos_val;
      logic [11:0] neg_val;
      logic [11:0] op_a;
      logic [11:0] op_b;
      run         = 1'b0;
      restart     = 1'b0;
      load_req    = 1'b0;
      load_addr   = '0;
      load_data   = '0;
      rd_req      = 1'b0;
      rd_index    = '0;
      error_count = 0;
      lfsr_state  = 32'hc6b8;
      branch_funct = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      wait_level("arst_n", 1'b1, 10);

      // Reset state, before any run
      check_value("load_ack", load_ack, 0);
      check_value("rd_ack", rd_ack, 0);
      check_value("halted", halted, 0);
      for (int i = 0; i < rv_pkg::REG_COUNT; i++) begin
         exp_regs[i] = rv_pkg::word_t'(i);
      end
      check_all_regs();

      // 40 random ALU instructions then jump-to-self
      for (int i = 0; i < 40; i++) begin
         prog[i] = random_alu_instr();
      end
      prog[40] = enc_j(0, rv_pkg::reg_idx_t'(get_bits(5)));
      run_program(41);
      held_readout(rv_pkg::reg_idx_t'(1 + get_bits(4)));

      // Upper immediates with forward and backward jumps
      prog[0]  = enc_u(rv_pkg::OPC_LUI, 20'(get_bits(20)), 5'd1);
      prog[1]  = enc_u(rv_pkg::OPC_AUIPC, 20'(get_bits(20)), 5'd2);
      prog[2]  = enc_j(8, 5'd3);
      prog[3]  = enc_u(rv_pkg::OPC_LUI, 20'(get_bits(20)), 5'd4);
      prog[4]  = enc_u(rv_pkg::OPC_AUIPC, 20'(get_bits(20)), 5'd5);
      prog[5]  = enc_j(12, 5'd6);
      prog[6]  = enc_u(rv_pkg::OPC_LUI, 20'(get_bits(20)), 5'd7);
      prog[7]  = enc_u(rv_pkg::OPC_LUI, 20'(get_bits(20)), 5'd8);
      prog[8]  = enc_j(12, 5'd9);
      prog[9]  = enc_j(0, 5'd13);
      prog[10] = enc_u(rv_pkg::OPC_LUI, 20'(get_bits(20)), 5'd10);
      prog[11] = enc_u(rv_pkg::OPC_AUIPC, 20'(get_bits(20)), 5'd11);
      prog[12] = enc_j(-12, 5'd12);
      run_program(13);

      // Each branch with mixed-sign and equal operands
      // x3 marks the fall-through path and x4 the taken one
      for (int f = 0; f < 6; f++) begin
         for (int c = 0; c < 3; c++) begin
            pos_val = 12'(1 + get_bits(10));
            neg_val = 12'(-(1 + get_bits(10)));
            op_a    = (c == 1) ? neg_val : pos_val;
            op_b    = (c == 0) ? neg_val : pos_val;
            prog[0] = enc_i(op_a, 3'd0, 5'd1, 5'd0);
            prog[1] = enc_i(op_b, 3'd0, 5'd2, 5'd0);
            prog[2] = enc_b(12, branch_funct[f], 5'd1, 5'd2);
            prog[3] = enc_i(12'h011, 3'd0, 5'd3, 5'd0);
            prog[4] = enc_j(8, 5'd0);
            prog[5] = enc_i(12'h022, 3'd0, 5'd4, 5'd0);
            prog[6] = enc_j(0, 5'd0);
            run_program(7);
         end
      end

      if (error_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== design/decode_if.sv ====
// Decoded instruction bundle from the decoder to the ALU and the register file
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

   rv_pkg::alu_op_e  op;
   rv_pkg::reg_idx_t rd;
   rv_pkg::reg_idx_t rs1;
   rv_pkg::reg_idx_t rs2;
   rv_pkg::word_t    imm;
   // Instruction writes a nonzero rd
   logic             wr_en;

   modport producer (output op, rd, rs1, rs2, imm, wr_en);

   // ALU needs only the operation and immediate
   modport consumer_alu (input op, imm);

   modport consumer_rf (input rs1, rs2, rd, wr_en);

endinterface

`default_nettype wire

// ==== design/instr_fetch.sv ====
// Program memory with four-phase load port, program counter and halt on jump-to-self
`timescale 1ns/1ps
`default_nettype none

module instr_fetch (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               run,
   input  logic               load_req,
   input  rv_pkg::imem_addr_t load_addr,
   input  rv_pkg::word_t      load_data,
   output logic               load_ack,
   input  rv_pkg::word_t      next_pc,
   output rv_pkg::word_t      pc,
   output rv_pkg::word_t      instr,
   output logic               halted
);

   rv_pkg::word_t      imem [rv_pkg::IMEM_WORDS];
   rv_pkg::imem_addr_t fetch_addr;
   logic               load_accept;
   logic               stepping;
   logic               self_jump;

   // New request, previous one done, core stopped
   assign load_accept = load_req & ~load_ack & ~run;

   always_ff @(posedge clk) begin
      if (load_accept) begin
         imem[load_addr] <= load_data;
      end
   end

   // Ack follows req by one clock in both directions
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         load_ack <= 1'b0;
      end else if (load_accept) begin
         load_ack <= 1'b1;
      end else if (!load_req) begin
         load_ack <= 1'b0;
      end
   end

   // Word address from byte pc
   assign fetch_addr = pc[2 +: $bits(rv_pkg::imem_addr_t)];
   assign instr      = imem[fetch_addr];

   // JAL with all-zero offset ends the program
   assign self_jump = (instr[6:0] == rv_pkg::OPC_JAL) && (instr[31:12] == '0);

   assign stepping = run & ~halted;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc     <= '0;
         halted <= 1'b0;
      end else if (stepping) begin
         // Jump-to-self target equals pc, so pc holds after the stop
         pc <= next_pc;
         if (self_jump) begin
            halted <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
// 32x32 register file with two operand reads, one write and a readout peek port
`timescale 1ns/1ps
`default_nettype none

module reg_file (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             commit,
   decode_if.consumer_rf    dec,
   input  rv_pkg::word_t    wr_data,
   output rv_pkg::word_t    src1,
   output rv_pkg::word_t    src2,
   input  rv_pkg::reg_idx_t peek_index,
   output rv_pkg::word_t    peek_data
);

   rv_pkg::word_t regs [rv_pkg::REG_COUNT];

   // Reset loads xN with N
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < rv_pkg::REG_COUNT; i++) begin
            regs[i] <= rv_pkg::word_t'(i);
         end
      end else if (commit && dec.wr_en) begin
         // wr_en already excludes x0
         regs[dec.rd] <= wr_data;
      end
   end

   // x0 forced to zero on every read
   assign src1      = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
   assign src2      = (dec.rs2 == '0) ? '0 : regs[dec.rs2];
   assign peek_data = (peek_index == '0) ? '0 : regs[peek_index];

endmodule

`default_nettype wire

// ==== design/reg_readout.sv ====
// Four-phase register readout port; holds the read data while ack is high
`timescale 1ns/1ps
`default_nettype none

module reg_readout (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             rd_req,
   input  rv_pkg::reg_idx_t rd_index,
   output logic             rd_ack,
   output rv_pkg::word_t    rd_data,
   output rv_pkg::reg_idx_t peek_index,
   input  rv_pkg::word_t    peek_data
);

   rv_pkg::readout_state_e state;
   rv_pkg::word_t          data_q;

   // ACK is the first ack cycle
   // WAIT_DROP holds until req falls
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= rv_pkg::IDLE;
      end else begin
         case (state)
            rv_pkg::IDLE:      if (rd_req) state <= rv_pkg::ACK;
            rv_pkg::ACK:       state <= rd_req ? rv_pkg::WAIT_DROP : rv_pkg::IDLE;
            rv_pkg::WAIT_DROP: if (!rd_req) state <= rv_pkg::IDLE;
            default:           state <= rv_pkg::IDLE;
         endcase
      end
   end

   // Capture on the accepting edge only
   always_ff @(posedge clk) begin
      if (state == rv_pkg::IDLE && rd_req) begin
         data_q <= peek_data;
      end
   end

   // Register file peek follows the requested index
   assign peek_index = rd_index;
   assign rd_ack     = (state != rv_pkg::IDLE);
   assign rd_data    = data_q;

endmodule

`default_nettype wire

// ==== design/rv_alu.sv ====
// Result computation, branch decision and next pc selection
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
   decode_if.consumer_alu dec,
   input  rv_pkg::word_t  src1,
   input  rv_pkg::word_t  src2,
   input  rv_pkg::word_t  pc,
   output rv_pkg::word_t  result,
   output rv_pkg::word_t  next_pc
);

   rv_pkg::word_t                opb;
   rv_pkg::word_t                pc_plus4;
   rv_pkg::word_t                pc_plus_imm;
   logic [2*rv_pkg::XLEN-1:0]    sext_src1;
   rv_pkg::word_t                sra_res;
   logic                         lt_u;
   logic                         lt_s;
   logic                         eq;
   logic                         taken;

   // Second operand is imm for the I forms
   always_comb begin
      case (dec.op)
         rv_pkg::OP_ADDI, rv_pkg::OP_ANDI, rv_pkg::OP_ORI, rv_pkg::OP_XORI,
         rv_pkg::OP_SLLI, rv_pkg::OP_SRLI, rv_pkg::OP_SRAI,
         rv_pkg::OP_SLTI, rv_pkg::OP_SLTIU: opb = dec.imm;
         default:                            opb = src2;
      endcase
   end

   // Compares; signed one from sign bits
   assign eq   = (src1 == opb);
   assign lt_u = (src1 < opb);
   assign lt_s = (src1[rv_pkg::XLEN-1] == opb[rv_pkg::XLEN-1]) ? lt_u : src1[rv_pkg::XLEN-1];

   // Arithmetic shift through double-width sign extension
   assign sext_src1 = {{rv_pkg::XLEN{src1[rv_pkg::XLEN-1]}}, src1};
   assign sra_res   = rv_pkg::word_t'(sext_src1 >> opb[4:0]);

   assign pc_plus4    = pc + 32'd4;
   assign pc_plus_imm = pc + dec.imm;

   always_comb begin
      case (dec.op)
         rv_pkg::OP_ADD,  rv_pkg::OP_ADDI:  result = src1 + opb;
         rv_pkg::OP_SUB:                    result = src1 - opb;
         rv_pkg::OP_AND,  rv_pkg::OP_ANDI:  result = src1 & opb;
         rv_pkg::OP_OR,   rv_pkg::OP_ORI:   result = src1 | opb;
         rv_pkg::OP_XOR,  rv_pkg::OP_XORI:  result = src1 ^ opb;
         rv_pkg::OP_SLL,  rv_pkg::OP_SLLI:  result = src1 << opb[4:0];
         rv_pkg::OP_SRL,  rv_pkg::OP_SRLI:  result = src1 >> opb[4:0];
         rv_pkg::OP_SRA,  rv_pkg::OP_SRAI:  result = sra_res;
         rv_pkg::OP_SLT,  rv_pkg::OP_SLTI:  result = {31'b0, lt_s};
         rv_pkg::OP_SLTU, rv_pkg::OP_SLTIU: result = {31'b0, lt_u};
         rv_pkg::OP_LUI:                    result = dec.imm;
         rv_pkg::OP_AUIPC:                  result = pc_plus_imm;
         // Link address
         rv_pkg::OP_JAL:                    result = pc_plus4;
         default:                           result = '0;
      endcase
   end

   // Branch conditions, opb is src2 here
   always_comb begin
      case (dec.op)
         rv_pkg::OP_BEQ:  taken = eq;
         rv_pkg::OP_BNE:  taken = ~eq;
         rv_pkg::OP_BLT:  taken = lt_s;
         rv_pkg::OP_BGE:  taken = ~lt_s;
         rv_pkg::OP_BLTU: taken = lt_u;
         rv_pkg::OP_BGEU: taken = ~lt_u;
         rv_pkg::OP_JAL:  taken = 1'b1;
         default:         taken = 1'b0;
      endcase
   end

   assign next_pc = taken ? pc_plus_imm : pc_plus4;

endmodule

`default_nettype wire

// ==== design/rv_core_top.sv ====
// Top level of the single-cycle RV32I core; load and readout ports are plain
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               run,
   input  logic               load_req,
   input  rv_pkg::imem_addr_t load_addr,
   input  rv_pkg::word_t      load_data,
   output logic               load_ack,
   input  logic               rd_req,
   input  rv_pkg::reg_idx_t   rd_index,
   output logic               rd_ack,
   output rv_pkg::word_t      rd_data,
   output logic               halted
);

   rv_pkg::word_t    pc;
   rv_pkg::word_t    instr;
   rv_pkg::word_t    next_pc;
   rv_pkg::word_t    src1;
   rv_pkg::word_t    src2;
   rv_pkg::word_t    result;
   rv_pkg::reg_idx_t peek_index;
   rv_pkg::word_t    peek_data;
   logic             commit;

   decode_if dec_bus ();

   // Retire only while running and not stopped
   assign commit = run & ~halted;

   instr_fetch u_fetch (
      .clk       (clk),
      .arst_n    (arst_n),
      .run       (run),
      .load_req  (load_req),
      .load_addr (load_addr),
      .load_data (load_data),
      .load_ack  (load_ack),
      .next_pc   (next_pc),
      .pc        (pc),
      .instr     (instr),
      .halted    (halted)
   );

   rv_decoder u_decoder (
      .instr (instr),
      .dec   (dec_bus.producer)
   );

   rv_alu u_alu (
      .dec     (dec_bus.consumer_alu),
      .src1    (src1),
      .src2    (src2),
      .pc      (pc),
      .result  (result),
      .next_pc (next_pc)
   );

   reg_file u_regs (
      .clk        (clk),
      .arst_n     (arst_n),
      .commit     (commit),
      .dec        (dec_bus.consumer_rf),
      .wr_data    (result),
      .src1       (src1),
      .src2       (src2),
      .peek_index (peek_index),
      .peek_data  (peek_data)
   );

   reg_readout u_readout (
      .clk        (clk),
      .arst_n     (arst_n),
      .rd_req     (rd_req),
      .rd_index   (rd_index),
      .rd_ack     (rd_ack),
      .rd_data    (rd_data),
      .peek_index (peek_index),
      .peek_data  (peek_data)
   );

endmodule

`default_nettype wire

// ==== design/rv_decoder.sv ====
// Instruction decoder producing operation, register indices and immediate
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
   input  rv_pkg::word_t instr,
   decode_if.producer    dec
);

   rv_pkg::opcode_t opcode;
   logic [2:0]      funct3;
   logic            f7_bit5;
   rv_pkg::word_t   imm_i;
   rv_pkg::word_t   imm_u;
   rv_pkg::word_t   imm_b;
   rv_pkg::word_t   imm_j;
   rv_pkg::alu_op_e op_dec;
   rv_pkg::word_t   imm_dec;
   logic            writes_rd;

   // Instruction fields
   assign opcode  = instr[6:0];
   assign funct3  = instr[14:12];
   assign f7_bit5 = instr[30];

   assign dec.rd  = instr[11:7];
   assign dec.rs1 = instr[19:15];
   assign dec.rs2 = instr[24:20];

   // Sign-extended immediates per format
   assign imm_i = {{21{instr[31]}}, instr[30:20]};
   assign imm_u = {instr[31:12], 12'b0};
   assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      op_dec    = rv_pkg::OP_ILLEGAL;
      imm_dec   = '0;
      writes_rd = 1'b0;
      case (opcode)
         rv_pkg::OPC_OP: begin
            writes_rd = 1'b1;
            // funct7 bit 5 picks SUB and SRA
            case ({f7_bit5, funct3})
               4'b0_000: op_dec = rv_pkg::OP_ADD;
               4'b1_000: op_dec = rv_pkg::OP_SUB;
               4'b0_001: op_dec = rv_pkg::OP_SLL;
               4'b0_010: op_dec = rv_pkg::OP_SLT;
               4'b0_011: op_dec = rv_pkg::OP_SLTU;
               4'b0_100: op_dec = rv_pkg::OP_XOR;
               4'b0_101: op_dec = rv_pkg::OP_SRL;
               4'b1_101: op_dec = rv_pkg::OP_SRA;
               4'b0_110: op_dec = rv_pkg::OP_OR;
               4'b0_111: op_dec = rv_pkg::OP_AND;
               default:  op_dec = rv_pkg::OP_ILLEGAL;
            endcase
         end
         rv_pkg::OPC_OP_IMM: begin
            writes_rd = 1'b1;
            imm_dec   = imm_i;
            case (funct3)
               3'b000:  op_dec = rv_pkg::OP_ADDI;
               3'b001:  op_dec = f7_bit5 ? rv_pkg::OP_ILLEGAL : rv_pkg::OP_SLLI;
               3'b010:  op_dec = rv_pkg::OP_SLTI;
               3'b011:  op_dec = rv_pkg::OP_SLTIU;
               3'b100:  op_dec = rv_pkg::OP_XORI;
               3'b101:  op_dec = f7_bit5 ? rv_pkg::OP_SRAI : rv_pkg::OP_SRLI;
               3'b110:  op_dec = rv_pkg::OP_ORI;
               default: op_dec = rv_pkg::OP_ANDI;
            endcase
         end
         rv_pkg::OPC_LUI: begin
            writes_rd = 1'b1;
            imm_dec   = imm_u;
            op_dec    = rv_pkg::OP_LUI;
         end
         rv_pkg::OPC_AUIPC: begin
            writes_rd = 1'b1;
            imm_dec   = imm_u;
            op_dec    = rv_pkg::OP_AUIPC;
         end
         rv_pkg::OPC_JAL: begin
            writes_rd = 1'b1;
            imm_dec   = imm_j;
            op_dec    = rv_pkg::OP_JAL;
         end
         rv_pkg::OPC_BRANCH: begin
            imm_dec = imm_b;
            case (funct3)
               3'b000:  op_dec = rv_pkg::OP_BEQ;
               3'b001:  op_dec = rv_pkg::OP_BNE;
               3'b100:  op_dec = rv_pkg::OP_BLT;
               3'b101:  op_dec = rv_pkg::OP_BGE;
               3'b110:  op_dec = rv_pkg::OP_BLTU;
               3'b111:  op_dec = rv_pkg::OP_BGEU;
               default: op_dec = rv_pkg::OP_ILLEGAL;
            endcase
         end
         default: op_dec = rv_pkg::OP_ILLEGAL;
      endcase
   end

   assign dec.op  = op_dec;
   assign dec.imm = imm_dec;

   // No write for illegal encodings or x0
   assign dec.wr_en = writes_rd && (op_dec != rv_pkg::OP_ILLEGAL) && (instr[11:7] != '0);

endmodule

`default_nettype wire

// ==== design/rv_pkg.sv ====
// Shared widths, opcodes and enums for the RV32I core; referenced by scoped names
`default_nettype none

package rv_pkg;

   // Data path and storage sizes
   localparam int XLEN       = 32;
   localparam int REG_COUNT  = 32;
   localparam int IMEM_WORDS = 64;

   typedef logic [XLEN-1:0]               word_t;
   typedef logic [$clog2(REG_COUNT)-1:0]  reg_idx_t;
   typedef logic [$clog2(IMEM_WORDS)-1:0] imem_addr_t;
   typedef logic [6:0]                    opcode_t;

   // Major opcodes the decoder knows
   localparam opcode_t OPC_OP     = 7'b0110011;
   localparam opcode_t OPC_OP_IMM = 7'b0010011;
   localparam opcode_t OPC_LUI    = 7'b0110111;
   localparam opcode_t OPC_AUIPC  = 7'b0010111;
   localparam opcode_t OPC_JAL    = 7'b1101111;
   localparam opcode_t OPC_BRANCH = 7'b1100011;

   // One value per instruction
   typedef enum logic [4:0] {
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
      OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
      // Immediate forms
      OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
      OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
      // Upper immediates and jump
      OP_LUI, OP_AUIPC, OP_JAL,
      // Conditional branches
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
      OP_ILLEGAL
   } alu_op_e;

   // Register readout handshake states
   typedef enum logic [1:0] {
      IDLE,
      ACK,
      WAIT_DROP
   } readout_state_e;

endpackage

`default_nettype wire

// ==== project.f ====
design/rv_pkg.sv
design/decode_if.sv
design/instr_fetch.sv
design/rv_decoder.sv
design/rv_alu.sv
design/reg_file.sv
design/reg_readout.sv
design/rv_core_top.sv
bench/tb_clock.sv
bench/tb_rv_core.sv
